/* include/scandbl_defines.svh */
`ifndef SCANDBL_DEFINES_SVH
`define SCANDBL_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Line buffer geometry
//////////////////////////////////////////////////////////////////////

// Pixel index width inside one buffer half
// Gives up to 1024 pixels per source line, blanking included
`define SCANDBL_LINE_AW 10

// Source hsync before this pixel count is treated as a glitch
`define SCANDBL_MIN_LINE 128

//////////////////////////////////////////////////////////////////////
// Output sync timing in clkvga cycles
//////////////////////////////////////////////////////////////////////

// SVGA hsync of 3.36 us at 24 MHz
`define SCANDBL_HSYNC_COUNT 80

// SVGA vsync of 114.32 us at 24 MHz
`define SCANDBL_VSYNC_COUNT 2744

`endif

/* rtl/scandbl_pixel_pkg.sv */
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Pixel colour types
//////////////////////////////////////////////////////////////////////

package scandbl_pixel_pkg;

	// One colour channel, 8 levels
	typedef logic [2:0] color_t;

	// Full pixel as stored in the line buffer
	// Field order gives r in the top bits
	typedef struct packed {
		color_t r;
		color_t g;
		color_t b;
	} rgb_pixel_t;

endpackage

`default_nettype wire

/* rtl/scandbl_timing_pkg.sv */
`default_nettype none

`include "scandbl_defines.svh"

//////////////////////////////////////////////////////////////////////
// Line addressing and counter types
//////////////////////////////////////////////////////////////////////

package scandbl_timing_pkg;

	// Buffer address, half select on top of the pixel index
	typedef logic [`SCANDBL_LINE_AW:0] line_addr_t;

	// Pixel count or pixel index within one line
	typedef logic [`SCANDBL_LINE_AW-1:0] line_len_t;

	// Output vsync pulse counter
	typedef logic [15:0] vsync_cnt_t;

endpackage

`default_nettype wire

/* rtl/line_buf_if.sv */
`timescale 1ns/10ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Line buffer ports
//////////////////////////////////////////////////////////////////////

interface line_buf_if;

	// Write side, filled at source pixel rate
	logic wr_en;
	scandbl_timing_pkg::line_addr_t wr_addr;
	scandbl_pixel_pkg::rgb_pixel_t wr_data;

	// Read side, scanned at clkvga rate
	scandbl_timing_pkg::line_addr_t rd_addr;
	scandbl_pixel_pkg::rgb_pixel_t rd_data;

	// Capture block owns the write port
	modport writer (
		output wr_en,
		output wr_addr,
		output wr_data
	);

	// Replay block sends the address and gets data a cycle later
	modport reader (
		output rd_addr,
		input rd_data
	);

	// Memory side
	modport ram (
		input wr_en,
		input wr_addr,
		input wr_data,
		input rd_addr,
		output rd_data
	);

endinterface

`default_nettype wire

/* rtl/scan_line_ram.sv */
`timescale 1ns/10ps
`default_nettype none

`include "scandbl_defines.svh"

// Two line halves, each one full source line
module scan_line_ram (
	input logic clkvga,
	line_buf_if.ram buf_port
);

	localparam int DEPTH = 1 << (`SCANDBL_LINE_AW + 1);

	scandbl_pixel_pkg::rgb_pixel_t mem [0:DEPTH-1];

	// Registered read, data follows rd_addr by one cycle
	// Write lands at the same edge
	always_ff @(posedge clkvga) begin
		buf_port.rd_data <= mem[buf_port.rd_addr];
		if (buf_port.wr_en) begin
			mem[buf_port.wr_addr] <= buf_port.wr_data;
		end
	end

endmodule

`default_nettype wire

/* rtl/line_capture.sv */
`timescale 1ns/10ps
`default_nettype none

`include "scandbl_defines.svh"

module line_capture (
	input logic clkvga,
	input logic rst_n,
	input logic pix_ce,
	input logic hsync_ext_n,
	input scandbl_pixel_pkg::rgb_pixel_t pixel_in,
	line_buf_if.writer buf_port,
	output logic line_start,
	output scandbl_timing_pkg::line_len_t line_len,
	output logic wr_half
);

	// Index of the next pixel within the active half
	scandbl_timing_pkg::line_len_t pix_idx;

	// End of the current source line on this pixel
	logic line_end;

	//////////////////////////////////////////////////////////////////////
	// Line end detection
	//////////////////////////////////////////////////////////////////////

	// Hsync counts only once the line is long enough
	// Filters glitches and keeps a long sync from switching twice
	assign line_end = pix_ce && !hsync_ext_n &&
		(pix_idx >= scandbl_timing_pkg::line_len_t'(`SCANDBL_MIN_LINE));

	//////////////////////////////////////////////////////////////////////
	// Buffer write port
	//////////////////////////////////////////////////////////////////////

	// One write per source pixel
	assign buf_port.wr_en = pix_ce;
	assign buf_port.wr_data = pixel_in;

	// Pixel that ends a line is pixel 0 of the other half
	always_comb begin
		if (line_end) begin
			buf_port.wr_addr = {~wr_half, {`SCANDBL_LINE_AW{1'b0}}};
		end else begin
			buf_port.wr_addr = {wr_half, pix_idx};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Index, half select and line length
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clkvga or negedge rst_n) begin
		if (!rst_n) begin
			pix_idx <= '0;
			wr_half <= 1'b0;
			line_len <= '0;
			line_start <= 1'b0;
		end else begin
			// Single cycle strobe, half already flipped when seen
			line_start <= line_end;
			if (line_end) begin
				// Pixels written so far make the finished line
				line_len <= pix_idx;
				wr_half <= ~wr_half;
				// Pixel 0 already went in, carry on from 1
				pix_idx <= scandbl_timing_pkg::line_len_t'(1);
			end else if (pix_ce) begin
				pix_idx <= pix_idx + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/line_replay.sv */
`timescale 1ns/10ps
`default_nettype none

`include "scandbl_defines.svh"

module line_replay (
	input logic clkvga,
	input logic rst_n,
	input logic line_start,
	input logic wr_half,
	input scandbl_timing_pkg::line_len_t line_len,
	line_buf_if.reader buf_port,
	output scandbl_pixel_pkg::color_t ro,
	output scandbl_pixel_pkg::color_t go,
	output scandbl_pixel_pkg::color_t bo,
	output logic hsync
);

	// Read position
	scandbl_timing_pkg::line_len_t rd_idx;
	logic rd_half;

	// Nothing to show until the first line is stored
	logic active;

	// Brightness of the replay in progress
	logic dim;

	// Stage aligned with the RAM output
	logic dim_q;

	// Last pixel of the stored line
	scandbl_timing_pkg::line_len_t last_idx;
	logic at_last;

	assign last_idx = line_len - 1'b1;
	assign at_last = (rd_idx == last_idx);

	// Address goes straight to the RAM
	assign buf_port.rd_addr = {rd_half, rd_idx};

	//////////////////////////////////////////////////////////////////////
	// Read scan at double rate
	//////////////////////////////////////////////////////////////////////

	// A new line restarts in the half just completed
	// Otherwise the same half is scanned again from 0
	// Either restart toggles the brightness
	always_ff @(posedge clkvga or negedge rst_n) begin
		if (!rst_n) begin
			rd_idx <= '0;
			rd_half <= 1'b0;
			active <= 1'b0;
			dim <= 1'b1;
		end else if (line_start) begin
			rd_idx <= '0;
			rd_half <= ~wr_half;
			active <= 1'b1;
			dim <= ~dim;
		end else if (active) begin
			if (at_last) begin
				rd_idx <= '0;
				dim <= ~dim;
			end else begin
				rd_idx <= rd_idx + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output stage
	//////////////////////////////////////////////////////////////////////

	// Hsync and dim follow the address by one cycle, like rd_data
	// Hsync low for the first pixels of each replay
	always_ff @(posedge clkvga or negedge rst_n) begin
		if (!rst_n) begin
			hsync <= 1'b1;
			dim_q <= 1'b1;
		end else begin
			hsync <= !(active &&
				(rd_idx < scandbl_timing_pkg::line_len_t'(`SCANDBL_HSYNC_COUNT)));
			dim_q <= dim;
		end
	end

	// Scanline effect, half level on dimmed replays
	assign ro = dim_q ? {1'b0, buf_port.rd_data.r[2:1]} : buf_port.rd_data.r;
	assign go = dim_q ? {1'b0, buf_port.rd_data.g[2:1]} : buf_port.rd_data.g;
	assign bo = dim_q ? {1'b0, buf_port.rd_data.b[2:1]} : buf_port.rd_data.b;

endmodule

`default_nettype wire

/* rtl/vsync_stretch.sv */
`timescale 1ns/10ps
`default_nettype none

`include "scandbl_defines.svh"

module vsync_stretch (
	input logic clkvga,
	input logic rst_n,
	input logic vsync_ext_n,
	output logic vsync
);

	// Armed, driving the pulse, or waiting for the source to release
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PULSE,
		ST_WAIT
	} vs_state_t;

	vs_state_t state;
	scandbl_timing_pkg::vsync_cnt_t cnt;

	//////////////////////////////////////////////////////////////////////
	// Pulse FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clkvga or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					// Falling source vsync starts the pulse
					if (!vsync_ext_n) begin
						state <= ST_PULSE;
						cnt <= '0;
					end
				end
				ST_PULSE: begin
					if (vsync_ext_n) begin
						// Source released early, end now
						state <= ST_IDLE;
					end else if (cnt ==
						scandbl_timing_pkg::vsync_cnt_t'(`SCANDBL_VSYNC_COUNT - 1)) begin
						state <= ST_WAIT;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_WAIT: begin
					// No retrigger until the source goes high
					if (vsync_ext_n) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Low only while pulsing
	assign vsync = (state != ST_PULSE);

endmodule

`default_nettype wire

/* rtl/vga_scandoubler.sv */
`timescale 1ns/10ps
`default_nettype none

module vga_scandoubler (
	input logic clkvga,
	input logic rst_n,
	input logic pix_ce,
	input logic hsync_ext_n,
	input logic vsync_ext_n,
	input logic [2:0] ri,
	input logic [2:0] gi,
	input logic [2:0] bi,
	output logic [2:0] ro,
	output logic [2:0] go,
	output logic [2:0] bo,
	output logic hsync,
	output logic vsync
);

	// Source pixel as one word
	scandbl_pixel_pkg::rgb_pixel_t pixel_in;

	// Capture to replay handover
	logic line_start;
	scandbl_timing_pkg::line_len_t line_len;
	logic wr_half;

	assign pixel_in.r = ri;
	assign pixel_in.g = gi;
	assign pixel_in.b = bi;

	line_buf_if buf_if ();

	//////////////////////////////////////////////////////////////////////
	// Line storage
	//////////////////////////////////////////////////////////////////////

	scan_line_ram scan_line_ram_i (
		.clkvga(clkvga),
		.buf_port(buf_if.ram)
	);

	// Writes source pixels and measures each line
	line_capture line_capture_i (
		.clkvga(clkvga),
		.rst_n(rst_n),
		.pix_ce(pix_ce),
		.hsync_ext_n(hsync_ext_n),
		.pixel_in(pixel_in),
		.buf_port(buf_if.writer),
		.line_start(line_start),
		.line_len(line_len),
		.wr_half(wr_half)
	);

	//////////////////////////////////////////////////////////////////////
	// VGA side
	//////////////////////////////////////////////////////////////////////

	// Each stored line shown twice with scanlines
	line_replay line_replay_i (
		.clkvga(clkvga),
		.rst_n(rst_n),
		.line_start(line_start),
		.wr_half(wr_half),
		.line_len(line_len),
		.buf_port(buf_if.reader),
		.ro(ro),
		.go(go),
		.bo(bo),
		.hsync(hsync)
	);

	vsync_stretch vsync_stretch_i (
		.clkvga(clkvga),
		.rst_n(rst_n),
		.vsync_ext_n(vsync_ext_n),
		.vsync(vsync)
	);

endmodule

`default_nettype wire

/* sim/tb_vga_scandoubler.sv */
`timescale 1ns/10ps
`default_nettype none

`include "scandbl_defines.svh"

module tb_vga_scandoubler;

	localparam int NUM_LINES = 7;
	localparam int GLITCH_LINE = 4;
	localparam int LONG_LOW = 3000;
	localparam int SHORT_LOW = 100;
	localparam int VS_TAIL = 20;
	localparam int VSYNC_TEST_CYCLES = LONG_LOW + SHORT_LOW + 2 * (VS_TAIL + 2);

	logic clkvga;
	logic rst_n;
	logic pix_ce;
	logic hsync_ext_n;
	logic vsync_ext_n;
	logic [2:0] ri;
	logic [2:0] gi;
	logic [2:0] bi;
	logic [2:0] ro;
	logic [2:0] go;
	logic [2:0] bo;
	logic hsync;
	logic vsync;

	// Source line lengths in pixels
	int line_lens [0:NUM_LINES-1] = '{200, 200, 300, 150, 200, 256, 200};
	// Every pixel sent by line and index
	logic [8:0] sent_px [0:NUM_LINES-1][0:1023];
	int seed = 53682;

	// High with pixel 0 of each new line that ends done_line
	logic line_boundary;
	int done_line;
	logic vs_test_on;

	// Replay position tracked by the checker
	logic model_active;
	int cur_line;
	int cur_idx;
	int replay_cnt;
	int start_delay;
	int pending_line;
	logic [8:0] exp_px;

	// Output hsync pulses counted from the DUT
	logic hsync_prev;
	int hsync_falls;

	int cycle_cnt;
	int timeout_limit;

	vga_scandoubler vga_scandoubler_i (
		.clkvga(clkvga),
		.rst_n(rst_n),
		.pix_ce(pix_ce),
		.hsync_ext_n(hsync_ext_n),
		.vsync_ext_n(vsync_ext_n),
		.ri(ri),
		.gi(gi),
		.bi(bi),
		.ro(ro),
		.go(go),
		.bo(bo),
		.hsync(hsync),
		.vsync(vsync)
	);

	initial begin
		clkvga = 1'b0;
		forever #5 clkvga = ~clkvga;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model and error exit
	//////////////////////////////////////////////////////////////////////

	// Odd replay count shows full level
	// Even count shows the dimmed scanline
	function automatic logic [8:0] expected_pixel(input int line_no, input int idx,
		input int replay);
		logic [8:0] px;
		px = sent_px[line_no][idx];
		if (replay % 2 == 1) begin
			return px;
		end
		return {1'b0, px[8:7], 1'b0, px[5:4], 1'b0, px[2:1]};
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	// One source line with a pixel on every second cycle
	// Hsync low for pixels 0 to 15
	// Optional glitch at pixels 50 and 51
	task automatic send_line(input int line_no, input bit glitch);
		int p;
		int rnd;
		logic [8:0] px;
		for (p = 0; p < line_lens[line_no]; p++) begin
			@(posedge clkvga);
			#1;
			rnd = $random(seed);
			px = rnd[8:0];
			sent_px[line_no][p] = px;
			{ri, gi, bi} = px;
			pix_ce = 1'b1;
			hsync_ext_n = !((p < 16) || (glitch && (p == 50 || p == 51)));
			line_boundary = (p == 0) && (line_no > 0);
			done_line = line_no - 1;
			@(posedge clkvga);
			#1;
			pix_ce = 1'b0;
			line_boundary = 1'b0;
		end
	endtask

	// Holds the source vsync low and counts output low cycles
	task automatic pulse_vsync(input int low_cycles, input int expect_low);
		int low_seen;
		low_seen = 0;
		@(posedge clkvga);
		#1;
		vs_test_on = 1'b1;
		vsync_ext_n = 1'b0;
		repeat (low_cycles) begin
			@(negedge clkvga);
			if (!vsync) begin
				low_seen++;
			end
		end
		@(posedge clkvga);
		#1;
		vsync_ext_n = 1'b1;
		repeat (VS_TAIL) begin
			@(negedge clkvga);
			if (!vsync) begin
				low_seen++;
			end
		end
		assert (low_seen == expect_low) else stop_on_error($sformatf(
			"FAILED at %0t: vsync low for %0d cycles, expected %0d",
			$time, low_seen, expect_low));
		@(posedge clkvga);
		#1;
		vs_test_on = 1'b0;
	endtask

	initial begin
		rst_n = 1'b0;
		pix_ce = 1'b0;
		hsync_ext_n = 1'b1;
		vsync_ext_n = 1'b1;
		ri = 3'd0;
		gi = 3'd0;
		bi = 3'd0;
		line_boundary = 1'b0;
		done_line = 0;
		vs_test_on = 1'b0;
		repeat (4) @(posedge clkvga);
		#1;
		rst_n = 1'b1;
		for (int n = 0; n < NUM_LINES; n++) begin
			send_line(n, n == GLITCH_LINE);
		end
		// Capture stops here and the last stored line keeps looping
		pulse_vsync(LONG_LOW, `SCANDBL_VSYNC_COUNT);
		pulse_vsync(SHORT_LOW, SHORT_LOW);
		// Each replay must have come with its own hsync pulse
		assert (hsync_falls == replay_cnt) else stop_on_error($sformatf(
			"FAILED at %0t: %0d hsync pulses, expected %0d",
			$time, hsync_falls, replay_cnt));
		$display("Everything OK");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Output comparison on the falling edge
	//////////////////////////////////////////////////////////////////////

	initial begin
		model_active = 1'b0;
		cur_line = 0;
		cur_idx = 0;
		replay_cnt = 0;
		start_delay = 0;
		pending_line = 0;
		hsync_prev = 1'b1;
		hsync_falls = 0;
	end

	// A line end sampled at edge E0 shows its pixel 0 after edge E0 + 2
	always @(negedge clkvga) begin
		if (rst_n) begin
			if (start_delay == 1) begin
				start_delay = 0;
				cur_line = pending_line;
				cur_idx = 0;
				replay_cnt++;
				model_active = 1'b1;
			end else begin
				if (start_delay != 0) begin
					start_delay--;
				end
				// Same line again from 0 after its last pixel
				if (model_active) begin
					if (cur_idx == line_lens[cur_line] - 1) begin
						cur_idx = 0;
						replay_cnt++;
					end else begin
						cur_idx++;
					end
				end
			end
			if (line_boundary) begin
				start_delay = 3;
				pending_line = done_line;
			end
			// Falling output hsync marks one replay start
			if (hsync_prev && !hsync) begin
				hsync_falls++;
			end
			hsync_prev = hsync;
			if (model_active) begin
				exp_px = expected_pixel(cur_line, cur_idx, replay_cnt);
				assert ({ro, go, bo} === exp_px) else stop_on_error($sformatf(
					"FAILED at %0t: line %0d pixel %0d replay %0d got %h expected %h",
					$time, cur_line, cur_idx, replay_cnt, {ro, go, bo}, exp_px));
				assert (hsync === (cur_idx >= `SCANDBL_HSYNC_COUNT)) else
					stop_on_error($sformatf("FAILED at %0t: hsync %b at replay pixel %0d",
					$time, hsync, cur_idx));
			end else begin
				assert (hsync === 1'b1) else stop_on_error($sformatf(
					"FAILED at %0t: hsync low before the first line", $time));
			end
			if (!vs_test_on) begin
				assert (vsync === 1'b1) else stop_on_error($sformatf(
					"FAILED at %0t: vsync low without source vsync", $time));
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Timeout
	//////////////////////////////////////////////////////////////////////

	// Limit is 1.5 times the stimulus length in cycles
	initial begin
		int line_pix;
		line_pix = 0;
		cycle_cnt = 0;
		foreach (line_lens[i]) begin
			line_pix += line_lens[i];
		end
		timeout_limit = (3 * (2 * line_pix + VSYNC_TEST_CYCLES)) / 2;
		forever begin
			@(posedge clkvga);
			cycle_cnt++;
			if (cycle_cnt >= timeout_limit) begin
				stop_on_error($sformatf("Timeout: run passed %0d cycles", timeout_limit));
			end
		end
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
rtl/scandbl_pixel_pkg.sv
rtl/scandbl_timing_pkg.sv
rtl/line_buf_if.sv
rtl/scan_line_ram.sv
rtl/line_capture.sv
rtl/line_replay.sv
rtl/vsync_stretch.sv
rtl/vga_scandoubler.sv
sim/tb_vga_scandoubler.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the scan doubler testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_vga_scandoubler \
	-f filelist.f \
	-o sim_tb

# Log is searched below for the result
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "Everything OK" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"
